// File: hdl/pipe_pkg.sv
package pipe_pkg;

  localparam int NUM_REGS   = 8;
  localparam int REG_SEL_W  = $clog2(NUM_REGS);  // bits that pick a physical register
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [1:0]  fwd_sel_t;

  // forward select codes
  localparam fwd_sel_t FWD_NONE = 2'b00;
  localparam fwd_sel_t FWD_WB   = 2'b01;
  localparam fwd_sel_t FWD_MEM  = 2'b10;

  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  typedef enum logic {
    ALU_ADD,
    ALU_SUB
  } alu_op_e;

  typedef struct packed {
    logic stall;  // hold the register feeding this stage
    logic flush;  // load a bubble instead
  } stage_ctrl_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
  } retire_t;

  // all zero is a no-op
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    use_imm;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

// File: hdl/pipe_regfile.sv
`timescale 1ns/10ps

module pipe_regfile (
  input  logic               clk_i,
  input  logic               rst_i,
  input  pipe_pkg::reg_idx_t rs1_i,
  input  pipe_pkg::reg_idx_t rs2_i,
  output pipe_pkg::word_t    rd1_o,
  output pipe_pkg::word_t    rd2_o,
  input  logic               wr_en_i,
  input  pipe_pkg::reg_idx_t wr_idx_i,
  input  pipe_pkg::word_t    wr_data_i
);

  pipe_pkg::word_t regs [pipe_pkg::NUM_REGS];
  logic [pipe_pkg::REG_SEL_W-1:0] wr_slot;
  logic [pipe_pkg::REG_SEL_W-1:0] rd1_slot;
  logic [pipe_pkg::REG_SEL_W-1:0] rd2_slot;
  logic wr_live;

  // upper register numbers alias by their low bits
  assign wr_slot  = wr_idx_i[pipe_pkg::REG_SEL_W-1:0];
  assign rd1_slot = rs1_i[pipe_pkg::REG_SEL_W-1:0];
  assign rd2_slot = rs2_i[pipe_pkg::REG_SEL_W-1:0];
  assign wr_live  = wr_en_i && (wr_slot != '0);  // x0 stays zero

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < pipe_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_live)
      regs[wr_slot] <= wr_data_i;
  end

  // write-through so decode sees the writeback value
  assign rd1_o = (wr_live && wr_slot == rd1_slot) ? wr_data_i : regs[rd1_slot];
  assign rd2_o = (wr_live && wr_slot == rd2_slot) ? wr_data_i : regs[rd2_slot];

endmodule

// File: hdl/pipe_decoder.sv
`timescale 1ns/10ps

module pipe_decoder (
  input  pipe_pkg::word_t    instr_i,
  output pipe_pkg::ctrl_t    ctrl_o,
  output pipe_pkg::reg_idx_t rs1_o,
  output pipe_pkg::reg_idx_t rs2_o,
  output pipe_pkg::reg_idx_t rd_o,
  output pipe_pkg::word_t    imm_o
);

  logic [6:0]      opcode;
  pipe_pkg::word_t imm_i_type;
  pipe_pkg::word_t imm_s_type;
  pipe_pkg::word_t imm_b_type;

  assign opcode = instr_i[6:0];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign rd_o   = instr_i[11:7];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};

  always_comb
  begin
    ctrl_o = '0;
    imm_o  = '0;
    case (opcode)
      pipe_pkg::OPC_REG:
      begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = instr_i[30] ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;  // funct7 bit
      end
      pipe_pkg::OPC_IMM:
      begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.use_imm   = 1'b1;
        imm_o            = imm_i_type;
      end
      pipe_pkg::OPC_LOAD:
      begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.mem_read  = 1'b1;
        ctrl_o.use_imm   = 1'b1;
        imm_o            = imm_i_type;
      end
      pipe_pkg::OPC_STORE:
      begin
        ctrl_o.mem_write = 1'b1;
        ctrl_o.use_imm   = 1'b1;
        imm_o            = imm_s_type;
      end
      pipe_pkg::OPC_BRANCH:
      begin
        ctrl_o.branch = 1'b1;
        ctrl_o.alu_op = pipe_pkg::ALU_SUB;  // equality via zero result
        imm_o         = imm_b_type;
      end
      default:
      begin
        ctrl_o = '0;  // unknown opcode, no-op
      end
    endcase
  end

endmodule

// File: hdl/pipe_alu_branch.sv
`timescale 1ns/10ps

module pipe_alu_branch (
  input  pipe_pkg::ctrl_t    ctrl_i,
  input  pipe_pkg::word_t    rs1_val_i,
  input  pipe_pkg::word_t    rs2_val_i,
  input  pipe_pkg::word_t    imm_i,
  input  pipe_pkg::addr_t    pc_i,
  input  pipe_pkg::fwd_sel_t fwd_a_i,
  input  pipe_pkg::fwd_sel_t fwd_b_i,
  input  pipe_pkg::word_t    mem_result_i,
  input  pipe_pkg::word_t    wb_result_i,
  output pipe_pkg::word_t    result_o,
  output pipe_pkg::word_t    store_data_o,
  output logic               taken_o,
  output pipe_pkg::addr_t    target_o
);

  pipe_pkg::word_t op_a;
  pipe_pkg::word_t reg_b;
  pipe_pkg::word_t op_b;

  function automatic pipe_pkg::word_t fwd_mux(input pipe_pkg::fwd_sel_t sel,
                                              input pipe_pkg::word_t reg_val,
                                              input pipe_pkg::word_t mem_val,
                                              input pipe_pkg::word_t wb_val);
    case (sel)
      pipe_pkg::FWD_MEM: return mem_val;
      pipe_pkg::FWD_WB:  return wb_val;
      default:           return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a_i, rs1_val_i, mem_result_i, wb_result_i);
  assign reg_b = fwd_mux(fwd_b_i, rs2_val_i, mem_result_i, wb_result_i);
  assign op_b  = ctrl_i.use_imm ? imm_i : reg_b;

  assign result_o     = (ctrl_i.alu_op == pipe_pkg::ALU_SUB) ? op_a - op_b : op_a + op_b;
  assign store_data_o = reg_b;  // forwarded rs2 for SW

  // BEQ taken when rs1 - rs2 is zero
  assign taken_o  = ctrl_i.branch && (result_o == '0);
  assign target_o = pc_i + imm_i;

endmodule

// File: hdl/pipe_hazard_unit.sv
`timescale 1ns/10ps

module pipe_hazard_unit (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  pipe_pkg::reg_idx_t    ex_rs1_i,
  input  pipe_pkg::reg_idx_t    ex_rs2_i,
  input  pipe_pkg::reg_idx_t    mem_rd_i,
  input  pipe_pkg::reg_idx_t    wb_rd_i,
  input  pipe_pkg::reg_idx_t    id_rs1_i,
  input  pipe_pkg::reg_idx_t    id_rs2_i,
  input  pipe_pkg::reg_idx_t    ex_rd_i,
  input  logic                  mem_reg_wr_i,
  input  logic                  wb_reg_wr_i,
  input  logic                  ex_mem_read_i,
  input  logic                  ex_branch_taken_i,
  output pipe_pkg::fwd_sel_t    fwd_a_o,
  output pipe_pkg::fwd_sel_t    fwd_b_o,
  output pipe_pkg::stage_ctrl_t if_ctrl_o,
  output pipe_pkg::stage_ctrl_t id_ctrl_o,
  output pipe_pkg::stage_ctrl_t ex_ctrl_o,
  output pipe_pkg::stage_ctrl_t mem_ctrl_o,
  output pipe_pkg::stage_ctrl_t wb_ctrl_o
);

  logic dmem_stall_q;
  logic load_use;
  logic redirect;

  // same physical register, x0 excluded
  function automatic logic hits(input pipe_pkg::reg_idx_t src, input pipe_pkg::reg_idx_t dst);
    return (src[pipe_pkg::REG_SEL_W-1:0] == dst[pipe_pkg::REG_SEL_W-1:0]) &&
           (src[pipe_pkg::REG_SEL_W-1:0] != '0);
  endfunction

  function automatic pipe_pkg::fwd_sel_t pick_fwd(input pipe_pkg::reg_idx_t src,
                                                  input pipe_pkg::reg_idx_t mem_rd,
                                                  input logic mem_wr,
                                                  input pipe_pkg::reg_idx_t wb_rd,
                                                  input logic wb_wr);
    if (mem_wr && hits(src, mem_rd))
      return pipe_pkg::FWD_MEM;  // youngest value wins
    else if (wb_wr && hits(src, wb_rd))
      return pipe_pkg::FWD_WB;
    else
      return pipe_pkg::FWD_NONE;
  endfunction

  // one cycle freeze while the data memory answers a load
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      dmem_stall_q <= 1'b0;
    else if (dmem_stall_q)
      dmem_stall_q <= 1'b0;
    else
      dmem_stall_q <= ex_mem_read_i;
  end

  assign fwd_a_o = pick_fwd(ex_rs1_i, mem_rd_i, mem_reg_wr_i, wb_rd_i, wb_reg_wr_i);
  assign fwd_b_o = pick_fwd(ex_rs2_i, mem_rd_i, mem_reg_wr_i, wb_rd_i, wb_reg_wr_i);

  assign load_use = ex_mem_read_i && (hits(id_rs1_i, ex_rd_i) || hits(id_rs2_i, ex_rd_i));
  // a branch frozen by the memory stall resolves on the next cycle
  assign redirect = ex_branch_taken_i && !dmem_stall_q;

  assign if_ctrl_o.stall  = load_use || dmem_stall_q;
  assign if_ctrl_o.flush  = 1'b0;
  assign id_ctrl_o.stall  = load_use || dmem_stall_q;
  assign id_ctrl_o.flush  = redirect;
  assign ex_ctrl_o.stall  = dmem_stall_q;
  assign ex_ctrl_o.flush  = (load_use && !dmem_stall_q) || redirect;  // bubble into execute
  assign mem_ctrl_o.stall = dmem_stall_q;
  assign mem_ctrl_o.flush = 1'b0;
  assign wb_ctrl_o.stall  = dmem_stall_q;
  assign wb_ctrl_o.flush  = 1'b0;

endmodule

// File: hdl/pipe_dmem.sv
`timescale 1ns/10ps

module pipe_dmem (
  input  logic            clk_i,
  input  logic            rst_i,
  input  pipe_pkg::addr_t addr_i,
  input  logic            rd_en_i,
  input  logic            wr_en_i,
  input  pipe_pkg::word_t wr_data_i,
  output pipe_pkg::word_t rd_data_o
);

  pipe_pkg::word_t mem [pipe_pkg::DMEM_WORDS];
  logic [pipe_pkg::DMEM_IDX_W-1:0] word_idx;

  assign word_idx = addr_i[pipe_pkg::DMEM_IDX_W+1:2];  // word addressed, byte offset dropped

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++)
        mem[i] <= '0;
      rd_data_o <= '0;
    end
    else
    begin
      if (wr_en_i)
        mem[word_idx] <= wr_data_i;
      if (rd_en_i)
        rd_data_o <= mem[word_idx];  // holds until the next read
    end
  end

endmodule

// File: hdl/pipe_core_top.sv
`timescale 1ns/10ps

module pipe_core_top (
  input  logic              clk_i,
  input  logic              rst_i,
  output pipe_pkg::addr_t   imem_addr_o,
  input  pipe_pkg::word_t   imem_rdata_i,
  output logic              retire_valid_o,
  output pipe_pkg::retire_t retire_o
);

  // per-stage hold and bubble controls
  pipe_pkg::stage_ctrl_t if_sc, id_sc, ex_sc, mem_sc, wb_sc;
  pipe_pkg::fwd_sel_t    fwd_a, fwd_b;

  pipe_pkg::addr_t    pc_q;
  pipe_pkg::word_t    if_id_instr;
  pipe_pkg::addr_t    if_id_pc;

  pipe_pkg::ctrl_t    dec_ctrl;
  pipe_pkg::reg_idx_t dec_rs1, dec_rs2, dec_rd;
  pipe_pkg::word_t    dec_imm, dec_rs1_val, dec_rs2_val;

  pipe_pkg::ctrl_t    id_ex_ctrl;
  pipe_pkg::reg_idx_t id_ex_rs1, id_ex_rs2, id_ex_rd;
  pipe_pkg::word_t    id_ex_rs1_val, id_ex_rs2_val, id_ex_imm;
  pipe_pkg::addr_t    id_ex_pc;

  pipe_pkg::word_t    ex_result, ex_store_data;
  logic               ex_taken;
  pipe_pkg::addr_t    ex_target;

  pipe_pkg::ctrl_t    ex_mem_ctrl;
  pipe_pkg::reg_idx_t ex_mem_rd;
  pipe_pkg::word_t    ex_mem_result;
  pipe_pkg::word_t    dmem_rdata;

  logic               mem_wb_reg_write;
  pipe_pkg::reg_idx_t mem_wb_rd;
  pipe_pkg::word_t    mem_wb_result;

  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pc_q <= '0;
    else if (!if_sc.stall)
      pc_q <= ex_taken ? ex_target : pc_q + 32'd4;
  end

  // control part of each pipeline register, bubble on reset or flush
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      if_id_instr      <= '0;  // opcode 0 decodes as no-op
      id_ex_ctrl       <= '0;
      ex_mem_ctrl      <= '0;
      mem_wb_reg_write <= 1'b0;
    end
    else
    begin
      if (!id_sc.stall)
        if_id_instr <= id_sc.flush ? '0 : imem_rdata_i;
      if (!ex_sc.stall)
        id_ex_ctrl <= ex_sc.flush ? '0 : dec_ctrl;
      if (!mem_sc.stall)
        ex_mem_ctrl <= mem_sc.flush ? '0 : id_ex_ctrl;
      if (!wb_sc.stall)
        mem_wb_reg_write <= wb_sc.flush ? 1'b0 : ex_mem_ctrl.reg_write;
    end
  end

  // payload, meaningless under a bubble
  always_ff @(posedge clk_i)
  begin
    if (!id_sc.stall)
      if_id_pc <= pc_q;
    if (!ex_sc.stall)
    begin
      id_ex_rs1     <= dec_rs1;
      id_ex_rs2     <= dec_rs2;
      id_ex_rd      <= dec_rd;
      id_ex_rs1_val <= dec_rs1_val;
      id_ex_rs2_val <= dec_rs2_val;
      id_ex_imm     <= dec_imm;
      id_ex_pc      <= if_id_pc;
    end
    if (!mem_sc.stall)
    begin
      ex_mem_rd     <= id_ex_rd;
      ex_mem_result <= ex_result;
    end
    if (!wb_sc.stall)
    begin
      mem_wb_rd     <= ex_mem_rd;
      mem_wb_result <= ex_mem_ctrl.mem_read ? dmem_rdata : ex_mem_result;  // load data or ALU
    end
  end

  pipe_decoder i_decoder (
    .instr_i (if_id_instr),
    .ctrl_o  (dec_ctrl),
    .rs1_o   (dec_rs1),
    .rs2_o   (dec_rs2),
    .rd_o    (dec_rd),
    .imm_o   (dec_imm)
  );

  pipe_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rs1_i     (dec_rs1),
    .rs2_i     (dec_rs2),
    .rd1_o     (dec_rs1_val),
    .rd2_o     (dec_rs2_val),
    .wr_en_i   (mem_wb_reg_write),
    .wr_idx_i  (mem_wb_rd),
    .wr_data_i (mem_wb_result)
  );

  pipe_alu_branch i_alu_branch (
    .ctrl_i       (id_ex_ctrl),
    .rs1_val_i    (id_ex_rs1_val),
    .rs2_val_i    (id_ex_rs2_val),
    .imm_i        (id_ex_imm),
    .pc_i         (id_ex_pc),
    .fwd_a_i      (fwd_a),
    .fwd_b_i      (fwd_b),
    .mem_result_i (ex_mem_result),
    .wb_result_i  (mem_wb_result),
    .result_o     (ex_result),
    .store_data_o (ex_store_data),
    .taken_o      (ex_taken),
    .target_o     (ex_target)
  );

  pipe_hazard_unit i_hazard_unit (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .ex_rs1_i          (id_ex_rs1),
    .ex_rs2_i          (id_ex_rs2),
    .mem_rd_i          (ex_mem_rd),
    .wb_rd_i           (mem_wb_rd),
    .id_rs1_i          (dec_rs1),
    .id_rs2_i          (dec_rs2),
    .ex_rd_i           (id_ex_rd),
    .mem_reg_wr_i      (ex_mem_ctrl.reg_write),
    .wb_reg_wr_i       (mem_wb_reg_write),
    .ex_mem_read_i     (id_ex_ctrl.mem_read),
    .ex_branch_taken_i (ex_taken),
    .fwd_a_o           (fwd_a),
    .fwd_b_o           (fwd_b),
    .if_ctrl_o         (if_sc),
    .id_ctrl_o         (id_sc),
    .ex_ctrl_o         (ex_sc),
    .mem_ctrl_o        (mem_sc),
    .wb_ctrl_o         (wb_sc)
  );

  // access only when execute advances so a frozen load keeps its data
  pipe_dmem i_dmem (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .addr_i    (ex_result),
    .rd_en_i   (id_ex_ctrl.mem_read && !ex_sc.stall),
    .wr_en_i   (id_ex_ctrl.mem_write && !ex_sc.stall),
    .wr_data_i (ex_store_data),
    .rd_data_o (dmem_rdata)
  );

  // retire once, on the cycle writeback moves on
  assign retire_valid_o = mem_wb_reg_write && !wb_sc.stall &&
                          (mem_wb_rd[pipe_pkg::REG_SEL_W-1:0] != '0);
  assign retire_o.rd    = mem_wb_rd;
  assign retire_o.data  = mem_wb_result;

endmodule

// File: verification/pipe_ref_model.svh
`ifndef PIPE_REF_MODEL_SVH
`define PIPE_REF_MODEL_SVH

// sequential ISA model over imem, stops at the closing self-loop
// fills exp_q with one record per write to a nonzero register
task automatic run_ref_model();
  pipe_pkg::word_t    regs [pipe_pkg::NUM_REGS];
  pipe_pkg::word_t    data [pipe_pkg::DMEM_WORDS];
  pipe_pkg::word_t    instr;
  pipe_pkg::word_t    a;
  pipe_pkg::word_t    b;
  pipe_pkg::word_t    val;
  pipe_pkg::word_t    imm_i;
  pipe_pkg::word_t    imm_s;
  pipe_pkg::word_t    imm_b;
  pipe_pkg::addr_t    pc;
  pipe_pkg::addr_t    ea;
  pipe_pkg::reg_idx_t rd;
  pipe_pkg::retire_t  rec;
  logic               wr;
  int                 steps;

  for (int i = 0; i < pipe_pkg::NUM_REGS; i++)
    regs[i] = '0;
  for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++)
    data[i] = '0;  // data memory is cleared by reset
  pc    = '0;
  steps = 0;
  while (pc != LOOP_IDX * 4 && steps < 4 * PROG_LEN)
  begin
    instr = imem[pc[7:2]];
    rd    = instr[11:7];
    a     = regs[instr[17:15]];  // low three bits of rs1
    b     = regs[instr[22:20]];  // low three bits of rs2
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    wr    = 1'b0;
    val   = '0;
    case (instr[6:0])
      pipe_pkg::OPC_REG:
      begin
        val = instr[30] ? a - b : a + b;
        wr  = 1'b1;
      end
      pipe_pkg::OPC_IMM:
      begin
        val = a + imm_i;
        wr  = 1'b1;
      end
      pipe_pkg::OPC_LOAD:
      begin
        ea  = a + imm_i;
        val = data[ea[7:2]];
        wr  = 1'b1;
      end
      pipe_pkg::OPC_STORE:
      begin
        ea             = a + imm_s;
        data[ea[7:2]]  = b;
      end
      default:
        ;  // anything else changes no state
    endcase
    if (instr[6:0] == pipe_pkg::OPC_BRANCH && a == b)
      pc = pc + imm_b;
    else
      pc = pc + 32'd4;
    if (wr && rd[2:0] != 3'd0)
    begin
      regs[rd[2:0]] = val;
      rec.rd        = rd;
      rec.data      = val;
      exp_q.push_back(rec);
    end
    steps++;
  end
endtask

`endif

// File: verification/pipe_core_tb.sv
`timescale 1ns/10ps

module pipe_core_tb;

  localparam int          PROG_LEN       = 48;
  localparam int          LOOP_IDX       = PROG_LEN - 1;  // BEQ x0,x0,0
  localparam int          IMEM_WORDS     = 64;
  localparam int          RESET_CYCLES   = 8;
  localparam int          TIMEOUT_CYCLES = PROG_LEN * 8 + RESET_CYCLES;
  localparam logic [31:0] SEED           = 32'h940;
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  logic              clk_i;
  logic              rst_i;
  pipe_pkg::addr_t   imem_addr;
  pipe_pkg::word_t   imem_rdata;
  logic              retire_valid;
  pipe_pkg::retire_t retire;

  pipe_pkg::word_t   imem [IMEM_WORDS];
  pipe_pkg::retire_t exp_q [$];
  logic [31:0]       lfsr_state;
  pipe_pkg::addr_t   last_addr;
  int                cycle_count;
  int                retire_count;
  int                loop_visits;
  int                fail_count;

  `include "pipe_ref_model.svh"

  pipe_core_top i_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .imem_addr_o    (imem_addr),
    .imem_rdata_i   (imem_rdata),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  assign imem_rdata = imem[imem_addr[7:2]];  // combinational instruction memory

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ LFSR_TAPS : state >> 1;
  endfunction

  // one LFSR step per bit
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < count; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits       = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic pipe_pkg::word_t r_type(input logic sub, input pipe_pkg::reg_idx_t rs2,
                                             input pipe_pkg::reg_idx_t rs1,
                                             input pipe_pkg::reg_idx_t rd);
    return {1'b0, sub, 5'b0, rs2, rs1, 3'b000, rd, pipe_pkg::OPC_REG};
  endfunction

  function automatic pipe_pkg::word_t i_type(input logic [11:0] imm,
                                             input pipe_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                             input pipe_pkg::reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic pipe_pkg::word_t s_type(input logic [11:0] imm,
                                             input pipe_pkg::reg_idx_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], pipe_pkg::OPC_STORE};  // base x0
  endfunction

  function automatic pipe_pkg::word_t b_type(input logic [12:0] imm,
                                             input pipe_pkg::reg_idx_t rs2,
                                             input pipe_pkg::reg_idx_t rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], pipe_pkg::OPC_BRANCH};
  endfunction

  task automatic build_program();
    logic [2:0]         kind;
    pipe_pkg::reg_idx_t rd;
    pipe_pkg::reg_idx_t rs1;
    pipe_pkg::reg_idx_t rs2;
    int                 off;
    for (int i = 0; i < IMEM_WORDS; i++)
      imem[i] = '0;  // opcode 0 past the end
    for (int i = 0; i < LOOP_IDX; i++)
    begin
      kind = 3'(take_bits(3));
      rd   = 5'(take_bits(3));
      rs1  = 5'(take_bits(3));
      rs2  = 5'(take_bits(3));
      case (kind)
        3'd0: imem[i] = r_type(1'b0, rs2, rs1, rd);
        3'd1: imem[i] = r_type(1'b1, rs2, rs1, rd);
        3'd2, 3'd3: imem[i] = i_type(12'(take_bits(12)), rs1, 3'b000, rd, pipe_pkg::OPC_IMM);
        3'd4: imem[i] = i_type(12'(take_bits(4) << 2), 5'd0, 3'b010, rd, pipe_pkg::OPC_LOAD);
        3'd5: imem[i] = s_type(12'(take_bits(4) << 2), rs2);
        3'd6:
        begin
          if (i <= LOOP_IDX - 4)
          begin
            off     = 2 + int'(take_bits(2)) % 3;  // forward 2 to 4 slots
            imem[i] = b_type(13'(off * 4), rs2, rs1);
          end
          else
            imem[i] = r_type(1'b0, rs2, rs1, rd);
        end
        default: imem[i] = {25'(take_bits(25)), 7'b0110111};  // LUI, not supported
      endcase
    end
    imem[LOOP_IDX] = b_type(13'd0, 5'd0, 5'd0);
  endtask

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at cycle %0d", cycle_count);
  endtask

  task automatic check_retire(input string name, input pipe_pkg::retire_t expected,
                              input pipe_pkg::retire_t actual);
    if (actual !== expected)
    begin
      fail_count++;
      $display("ERROR %s expected x%0d=%h actual x%0d=%h", name, expected.rd,
               expected.data, actual.rd, actual.data);
      stop_on_failure();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected)
    begin
      fail_count++;
      $display("ERROR %s expected %0d actual %0d", name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic take_retire();
    if (exp_q.size() == 0)
    begin
      $display("retire of x%0d seen with no expected record left", retire.rd);
      stop_on_failure();
    end
    else
    begin
      check_retire($sformatf("retire_%0d", retire_count), exp_q.pop_front(), retire);
      retire_count++;
    end
  endtask

  task automatic finish_run();
    check_count("leftover_retires", 0, exp_q.size());
    if (fail_count == 0)
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
    else
      stop_on_failure();
  endtask

  initial
  begin
    rst_i        = 1'b1;
    lfsr_state   = SEED;
    last_addr    = '0;
    cycle_count  = 0;
    retire_count = 0;
    loop_visits  = 0;
    fail_count   = 0;
    build_program();
    run_ref_model();
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
  end

  // outputs are settled at the falling edge
  always @(negedge clk_i)
  begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("timeout, the program did not reach its self-loop in %0d cycles",
               TIMEOUT_CYCLES);
      stop_on_failure();
    end
    else if (rst_i)
    begin
      if (cycle_count > 1 && retire_valid !== 1'b0)
      begin
        $display("retire_valid_o is not low during reset");
        stop_on_failure();
      end
    end
    else
    begin
      if (retire_valid === 1'b1)
        take_retire();
      if (imem_addr == LOOP_IDX * 4 && last_addr != LOOP_IDX * 4)
        loop_visits++;  // third visit means the loop branch has resolved twice
      last_addr = imem_addr;
      if (loop_visits == 3)
        finish_run();
    end
  end

endmodule

// File: vlog.f
+incdir+verification
hdl/pipe_pkg.sv
hdl/pipe_regfile.sv
hdl/pipe_decoder.sv
hdl/pipe_alu_branch.sv
hdl/pipe_hazard_unit.sv
hdl/pipe_dmem.sv
hdl/pipe_core_top.sv
verification/pipe_core_tb.sv

// File: Bender.yml
package:
  name: pipe_core

sources:
  - hdl/pipe_pkg.sv
  - hdl/pipe_regfile.sv
  - hdl/pipe_decoder.sv
  - hdl/pipe_alu_branch.sv
  - hdl/pipe_hazard_unit.sv
  - hdl/pipe_dmem.sv
  - hdl/pipe_core_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pipe_core_tb.sv
